// ==== Makefile ====
TOP := mtx_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module mtx -f verilog.f
	verilator --lint-only --timing --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f verilog.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/mtx_tb.sv ====
`timescale 1ns/1ps

module mtx_tb
   import mio_pkg::*, mio_regs_pkg::*;
();

   //################################################
   // run constants
   //################################################

   localparam logic [15:0] lfsr_seed = 16'd52004;
   localparam logic [15:0] lfsr_taps = 16'hb400;  // x^16 + x^14 + x^13 + x^11 + 1
   localparam int n_sdr_words    = 6;               // per width
   localparam int n_ddr_words    = 6;               // one beat each
   localparam int n_bp_words     = 12;              // width 16, four beats each
   localparam int n_dis_words    = 3;               // width 32, two beats each
   localparam int total_beats    = n_sdr_words * 15 + 48 + n_ddr_words +
                                   n_bp_words * 4 + n_dis_words * 2;
   localparam int timeout_margin = 1500;            // apb traffic and drains
   localparam int timeout_cycles = total_beats * 4 + timeout_margin;

   logic              io_clk;
   logic              io_nreset;
   logic [apb_aw-1:0] paddr;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [apb_dw-1:0] pwdata;
   logic [apb_dw-1:0] prdata;
   logic              pready;
   logic              pslverr;
   logic              core_valid;
   logic [iow_w-1:0]  core_data;
   logic [mask_w-1:0] core_mask;
   logic              core_ready;
   logic [iow_w-1:0]  tx_packet;
   logic              tx_access;
   logic              tx_wait;

   logic [15:0]       lfsr_q    = lfsr_seed;
   logic              ddr_mode  = 1'b0;      // monitor samples both phases
   io_width_e         cur_width = width_8;
   logic [iow_w-1:0]  exp_q[$];              // beats the rules predict
   logic [iow_w-1:0]  got_q[$];              // beats seen on the pins
   logic [iow_w-1:0]  mon_lo;
   int                exp_beats = 0;
   int                err_cnt   = 0;
   int                cycle_cnt = 0;

   mtx_tb_clk clk_i (.io_clk, .io_nreset);

   mtx mtx_i (
      .io_clk, .io_nreset,
      .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
      .core_valid, .core_data, .core_mask, .core_ready,
      .tx_packet, .tx_access, .tx_wait
   );

   //################################################
   // checks and helpers
   //################################################

   task automatic fail_stop(input string what);
      err_cnt++;
      $display("%s", what);
      $display("Errors found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_data(input string name, input logic [iow_w-1:0] got, exp);
      if (got !== exp) begin
         fail_stop($sformatf("Error: time %0t, %s got %h, expected %h", $time, name, got, exp));
      end
   endtask

   task automatic check_width(input string name, input io_width_e got, exp);
      if (got !== exp) begin
         fail_stop($sformatf("Error: time %0t, %s got %s, expected %s",
                             $time, name, got.name(), exp.name()));
      end
   endtask

   task automatic check_reg(input string name, input logic [apb_dw-1:0] got, exp);
      if (got !== exp) begin
         fail_stop($sformatf("Error: time %0t, %s got %h, expected %h", $time, name, got, exp));
      end
   endtask

   // galois lfsr, one step per bit taken
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      if (s[0]) begin
         return (s >> 1) ^ lfsr_taps;
      end
      return s >> 1;
   endfunction

   task automatic rand_bits(input int n, output logic [iow_w-1:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v[i]   = lfsr_q[0];
      end
   endtask

   function automatic int lane_bytes_of(input io_width_e w);
      case (w)
         width_8:  return 1;
         width_16: return 2;
         width_32: return 4;
         default:  return 8;
      endcase
   endfunction

   // bits of a beat that carry meaning
   function automatic logic [iow_w-1:0] lane_mask();
      if (ddr_mode || (cur_width == width_64)) begin
         return '1;
      end
      return (64'd1 << (lane_bytes_of(cur_width) * byte_w)) - 64'd1;
   endfunction

   function automatic logic [apb_dw-1:0] ctrl_value(input logic en, ddr, input io_width_e w);
      logic [apb_dw-1:0] v;
      v                          = '0;
      v[ctrl_en_bit]             = en;
      v[ctrl_ddr_bit]            = ddr;
      v[ctrl_width_lsb +: 2]     = w;
      return v;
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n) begin
         @(posedge io_clk);
         #10;
      end
   endtask

   //################################################
   // apb and core drivers
   //################################################

   task automatic apb_write(input logic [apb_aw-1:0] addr, input logic [apb_dw-1:0] data);
      psel    = 1'b1;                 // setup
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      wait_cycles(1);
      penable = 1'b1;                 // access, lands on next edge
      wait_cycles(1);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_read(input logic [apb_aw-1:0] addr, output logic [apb_dw-1:0] data,
                           output logic err);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      wait_cycles(1);
      penable = 1'b1;
      #20;                            // mid access phase
      data    = prdata;
      err     = pslverr;
      check_reg("pready", {31'b0, pready}, 32'd1);
      @(posedge io_clk);
      #10;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic set_ctrl(input logic en, ddr, input io_width_e w);
      apb_write(reg_ctrl_addr, ctrl_value(en, ddr, w));
      ddr_mode  = ddr;
      cur_width = w;
   endtask

   // beats a word should give, lowest lanes first
   task automatic add_expected(input logic [iow_w-1:0] data, input int nbytes);
      int lb;
      lb = lane_bytes_of(cur_width);
      if (ddr_mode) begin
         exp_q.push_back(data);
         exp_beats++;
      end else begin
         for (int k = 0; k < (nbytes + lb - 1) / lb; k++) begin
            exp_q.push_back(data >> (k * lb * byte_w));
            exp_beats++;
         end
      end
   endtask

   task automatic push_word(input logic [iow_w-1:0] data, input int nbytes);
      core_valid = 1'b1;
      core_data  = data;
      core_mask  = mask_w'((1 << nbytes) - 1);
      while (core_ready !== 1'b1) begin
         wait_cycles(1);               // buffer full
      end
      wait_cycles(1);                  // word moves on this edge
      core_valid = 1'b0;
      add_expected(data, nbytes);
   endtask

   task automatic push_random(input int n);
      logic [iow_w-1:0] d;
      for (int i = 0; i < n; i++) begin
         rand_bits(iow_w, d);
         push_word(d, mask_w);
      end
   endtask

   //################################################
   // pin monitor and timeout
   //################################################

   always begin
      @(posedge io_clk);
      #20;                            // clock high phase
      if (tx_access === 1'b1) begin
         mon_lo = tx_packet;
         if (ddr_mode) begin
            @(negedge io_clk);
            #20;                      // low phase carries the upper half
            got_q.push_back({tx_packet[ddr_w-1:0], mon_lo[ddr_w-1:0]});
         end else begin
            got_q.push_back(mon_lo);
         end
      end
   end

   always @(posedge io_clk) begin
      cycle_cnt++;
      if (cycle_cnt > timeout_cycles) begin
         fail_stop($sformatf("Timeout: run did not finish within %0d cycles", timeout_cycles));
      end
   end

   //################################################
   // test steps
   //################################################

   task automatic start_test();
      apb_write(reg_count_addr, '0);   // clears beat counter
      exp_beats = 0;
   endtask

   // poll status until buffer and shifter are empty
   task automatic drain();
      logic [apb_dw-1:0] rd;
      logic              err;
      rd = '1;
      while ((rd[stat_level_lsb +: lvl_w] != '0) || rd[stat_busy_bit]) begin
         apb_read(reg_status_addr, rd, err);
      end
   endtask

   task automatic check_beats();
      logic [iow_w-1:0] m;
      m = lane_mask();
      check_reg("beats seen", got_q.size(), exp_q.size());
      foreach (exp_q[i]) begin
         check_data("tx_packet", got_q[i] & m, exp_q[i] & m);
      end
      exp_q.delete();
      got_q.delete();
   endtask

   task automatic finish_test();
      logic [apb_dw-1:0] rd;
      logic              err;
      drain();
      check_beats();
      apb_read(reg_count_addr, rd, err);
      check_reg("count", rd, exp_beats);
   endtask

   task automatic test_registers();
      logic [apb_dw-1:0] rd;
      logic              err;
      apb_read(reg_status_addr, rd, err);
      check_reg("status", rd, '0);
      apb_read(reg_ctrl_addr, rd, err);
      check_reg("ctrl", rd, '0);
      apb_write(reg_ctrl_addr, ctrl_value(1'b0, 1'b1, width_32));  // link stays off
      apb_read(reg_ctrl_addr, rd, err);
      check_width("cfg_width", io_width_e'(rd[ctrl_width_lsb +: 2]), width_32);
      check_reg("ctrl", rd, ctrl_value(1'b0, 1'b1, width_32));
      check_reg("pslverr", {31'b0, err}, 32'd0);
      apb_read(8'h0c, rd, err);        // hole in the map
      check_reg("pslverr", {31'b0, err}, 32'd1);
      apb_write(reg_ctrl_addr, '0);
   endtask

   task automatic test_sdr_widths();
      for (int w = 0; w < 4; w++) begin
         set_ctrl(1'b1, 1'b0, io_width_e'(w[1:0]));
         start_test();
         push_random(n_sdr_words);
         finish_test();
      end
   endtask

   task automatic test_partial_masks();
      logic [iow_w-1:0] d;
      for (int p = 0; p < 2; p++) begin
         set_ctrl(1'b1, 1'b0, (p == 0) ? width_8 : width_32);
         start_test();
         for (int n = 1; n <= mask_w; n++) begin
            rand_bits(n * byte_w, d);  // bytes past the mask stay zero
            push_word(d, n);
         end
         finish_test();
      end
   endtask

   task automatic test_ddr();
      set_ctrl(1'b1, 1'b1, width_64);
      start_test();
      push_random(n_ddr_words);
      finish_test();
      set_ctrl(1'b0, 1'b0, width_64);
   endtask

   task automatic toggle_wait();
      tx_wait = 1'b0;
      wait_cycles(6);
      tx_wait = 1'b1;
      wait_cycles(5);
      tx_wait = 1'b0;
      wait_cycles(4);
      tx_wait = 1'b1;
      wait_cycles(3);
      tx_wait = 1'b0;
   endtask

   task automatic test_back_pressure();
      logic [apb_dw-1:0] rd;
      logic              err;
      set_ctrl(1'b1, 1'b0, width_16);
      start_test();
      tx_wait = 1'b1;
      wait_cycles(3);                  // through both sync flops
      push_random(fifo_depth);
      check_reg("core_ready", {31'b0, core_ready}, 32'd0);
      apb_read(reg_status_addr, rd, err);
      check_reg("status", rd, apb_dw'(fifo_depth) << stat_level_lsb);
      fork
         push_random(n_bp_words - fifo_depth);
         toggle_wait();
      join
      finish_test();
   endtask

   task automatic test_disable();
      logic [apb_dw-1:0] rd;
      logic              err;
      set_ctrl(1'b0, 1'b0, width_32);
      start_test();
      push_random(n_dis_words);
      apb_read(reg_status_addr, rd, err);
      check_reg("status", rd, apb_dw'(n_dis_words) << stat_level_lsb);
      check_reg("beats seen", got_q.size(), 32'd0);
      set_ctrl(1'b1, 1'b0, width_32);  // held words go out in order
      finish_test();
   endtask

   //################################################
   // main sequence
   //################################################

   initial begin
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = '0;
      pwdata     = '0;
      core_valid = 1'b0;
      core_data  = '0;
      core_mask  = '0;
      tx_wait    = 1'b0;
      wait (io_nreset === 1'b1);
      @(posedge io_clk);
      #10;
      test_registers();
      test_sdr_widths();
      test_partial_masks();
      test_ddr();
      test_back_pressure();
      test_disable();
      if (err_cnt == 0) begin
         $display("No errors");
         $finish;
      end else begin
         fail_stop("checks reported mismatches");
      end
   end

endmodule

// ==== dv/mtx_tb_clk.sv ====
`timescale 1ns/1ps

module mtx_tb_clk (
   output logic io_clk,
   output logic io_nreset
);

   localparam int half_period  = 50;   // 100 ns clock
   localparam int reset_cycles = 5;

   initial begin
      io_clk = 1'b0;
      forever #half_period io_clk = ~io_clk;
   end

   // release lines up with the stimulus offset
   initial begin
      io_nreset = 1'b0;
      repeat (reset_cycles) @(posedge io_clk);
      #10;
      io_nreset = 1'b1;
   end

endmodule

// ==== hw/mio_pkg.sv ====
package mio_pkg;

   //################################################
   // link geometry
   //################################################

   localparam int iow_w      = 64;            // pin and word width
   localparam int mask_w     = 8;             // byte lanes per word
   localparam int fifo_depth = 4;             // tx buffer entries

   // derived buffer sizes
   localparam int fifo_aw    = $clog2(fifo_depth);  // pointer bits
   localparam int lvl_w      = fifo_aw + 1;         // occupancy, holds 0..depth

   //################################################
   // beat helpers
   //################################################

   localparam int byte_w     = 8;             // bits per mask byte
   localparam int ddr_w      = iow_w / 2;     // pins used per ddr phase

   // beat width select, matches ctrl width field encoding
   typedef enum logic [1:0] {
      width_8  = 2'b00,                       // 1 byte per beat
      width_16 = 2'b01,                       // 2 bytes
      width_32 = 2'b10,                       // 4 bytes
      width_64 = 2'b11                        // whole word, one beat
   } io_width_e;

endpackage

// ==== hw/mio_regs_pkg.sv ====
package mio_regs_pkg;

   //################################################
   // apb bus geometry
   //################################################

   localparam int apb_aw = 8;                 // byte address bits
   localparam int apb_dw = 32;                // data bits

   // register map
   localparam logic [apb_aw-1:0] reg_ctrl_addr   = 8'h00;  // en, ddr, width
   localparam logic [apb_aw-1:0] reg_status_addr = 8'h04;  // level, busy
   localparam logic [apb_aw-1:0] reg_count_addr  = 8'h08;  // beats sent, wr clears

   // ctrl fields
   localparam int ctrl_en_bit    = 0;
   localparam int ctrl_ddr_bit   = 1;
   localparam int ctrl_width_lsb = 2;         // 2 bits wide

   // status fields
   localparam int stat_level_lsb = 0;         // buffer level, lvl_w bits
   localparam int stat_busy_bit  = 8;         // shifter holds bytes

   // apb phase tracking
   typedef enum logic [1:0] {
      apb_idle,
      apb_setup,
      apb_access
   } apb_op_e;

endpackage

// ==== hw/mtx.sv ====
`timescale 1ns/1ps

module mtx
   import mio_pkg::*, mio_regs_pkg::*;
(
   input  logic              io_clk,
   input  logic              io_nreset,
   // apb
   input  logic [apb_aw-1:0] paddr,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [apb_dw-1:0] pwdata,
   output logic [apb_dw-1:0] prdata,
   output logic              pready,
   output logic              pslverr,
   // core push
   input  logic              core_valid,
   input  logic [iow_w-1:0]  core_data,
   input  logic [mask_w-1:0] core_mask,
   output logic              core_ready,
   // chip pins
   output logic [iow_w-1:0]  tx_packet,
   output logic              tx_access,
   input  logic              tx_wait
);

   logic              cfg_en;
   logic              cfg_ddr;
   io_width_e         cfg_width;
   logic              buf_valid;
   logic [iow_w-1:0]  buf_data;
   logic [mask_w-1:0] buf_mask;
   logic [lvl_w-1:0]  buf_level;
   logic              buf_pop;
   logic              beat_sent;
   logic              io_busy;

   //################################################
   // config, buffer, pin stage
   //################################################

   mtx_cfg cfg_i (
      .io_clk, .io_nreset,
      .paddr, .psel, .penable, .pwrite, .pwdata,
      .prdata, .pready, .pslverr,
      .beat_sent, .io_busy, .buf_level,
      .cfg_en, .cfg_ddr, .cfg_width
   );

   mtx_fifo fifo_i (
      .io_clk, .io_nreset,
      .core_valid, .core_data, .core_mask, .core_ready,
      .buf_pop, .buf_valid, .buf_data, .buf_mask, .buf_level
   );

   mtx_io io_i (
      .io_clk, .io_nreset,
      .cfg_en, .cfg_ddr, .cfg_width,
      .buf_valid, .buf_data, .buf_mask, .buf_pop,
      .tx_packet, .tx_access, .tx_wait,
      .beat_sent, .io_busy
   );

endmodule

// ==== hw/mtx_cfg.sv ====
`timescale 1ns/1ps

module mtx_cfg
   import mio_pkg::*, mio_regs_pkg::*;
(
   input  logic              io_clk,
   input  logic              io_nreset,
   // apb slave
   input  logic [apb_aw-1:0] paddr,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [apb_dw-1:0] pwdata,
   output logic [apb_dw-1:0] prdata,
   output logic              pready,
   output logic              pslverr,
   // link status in
   input  logic              beat_sent,
   input  logic              io_busy,
   input  logic [lvl_w-1:0]  buf_level,
   // link config out
   output logic              cfg_en,
   output logic              cfg_ddr,
   output io_width_e         cfg_width
);

   apb_op_e           apb_state;   // phase of current transfer
   logic              acc_phase;   // second cycle of a legal transfer
   logic              addr_hit;    // paddr maps to a register
   logic              wr_en;
   logic              ctrl_wr;
   logic [apb_dw-1:0] count_q;     // beats put on pins
   logic [apb_dw-1:0] ctrl_word;
   logic [apb_dw-1:0] status_word;

   //################################################
   // apb decode
   //################################################

   // setup then access, anything else falls back to idle
   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         apb_state <= apb_idle;
      end else if (psel && !penable) begin
         apb_state <= apb_setup;
      end else if (acc_phase) begin
         apb_state <= apb_access;
      end else begin
         apb_state <= apb_idle;
      end
   end

   assign acc_phase = psel && penable && (apb_state == apb_setup);
   assign addr_hit  = (paddr == reg_ctrl_addr) || (paddr == reg_status_addr) ||
                      (paddr == reg_count_addr);
   assign wr_en     = acc_phase && pwrite && addr_hit;
   assign ctrl_wr   = wr_en && (paddr == reg_ctrl_addr);

   assign pready  = 1'b1;                      // zero wait states
   assign pslverr = acc_phase && !addr_hit;    // unmapped access

   //################################################
   // registers
   //################################################

   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         cfg_en    <= 1'b0;                    // link off after reset
         cfg_ddr   <= 1'b0;
         cfg_width <= width_8;
      end else if (ctrl_wr) begin
         cfg_en    <= pwdata[ctrl_en_bit];
         cfg_ddr   <= pwdata[ctrl_ddr_bit];
         cfg_width <= io_width_e'(pwdata[ctrl_width_lsb +: 2]);
      end
   end

   // beat counter, a write of any value clears it
   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         count_q <= '0;
      end else if (wr_en && (paddr == reg_count_addr)) begin
         count_q <= '0;
      end else if (beat_sent) begin
         count_q <= count_q + 1'b1;
      end
   end

   // read words
   always_comb begin
      ctrl_word                                = '0;
      ctrl_word[ctrl_en_bit]                   = cfg_en;
      ctrl_word[ctrl_ddr_bit]                  = cfg_ddr;
      ctrl_word[ctrl_width_lsb +: 2]           = cfg_width;
      status_word                              = '0;
      status_word[stat_level_lsb +: lvl_w]     = buf_level;
      status_word[stat_busy_bit]               = io_busy;
   end

   always_comb begin
      unique case (paddr)
         reg_ctrl_addr:   prdata = ctrl_word;
         reg_status_addr: prdata = status_word;
         reg_count_addr:  prdata = count_q;
         default:         prdata = '0;        // unmapped reads zero
      endcase
   end

   // changing width or ddr mid word would scramble the beat stream
   a_ctrl_when_idle: assert property (@(posedge io_clk) disable iff (!io_nreset)
      !(ctrl_wr && io_busy))
      else $error("mtx_cfg: control write while link busy");

endmodule

// ==== hw/mtx_fifo.sv ====
`timescale 1ns/1ps

module mtx_fifo
   import mio_pkg::*;
(
   input  logic              io_clk,
   input  logic              io_nreset,
   // core push side
   input  logic              core_valid,
   input  logic [iow_w-1:0]  core_data,
   input  logic [mask_w-1:0] core_mask,
   output logic              core_ready,
   // io pop side
   input  logic              buf_pop,
   output logic              buf_valid,
   output logic [iow_w-1:0]  buf_data,
   output logic [mask_w-1:0] buf_mask,
   output logic [lvl_w-1:0]  buf_level
);

   logic [iow_w-1:0]   data_mem [fifo_depth];  // payload storage
   logic [mask_w-1:0]  mask_mem [fifo_depth];
   logic [fifo_aw-1:0] wr_ptr;
   logic [fifo_aw-1:0] rd_ptr;
   logic [lvl_w-1:0]   count_q;                // words held
   logic               push;
   logic               pop;

   //################################################
   // handshake
   //################################################

   assign core_ready = (count_q != lvl_w'(fifo_depth));  // full drops ready
   assign push       = core_valid && core_ready;
   assign pop        = buf_pop;

   //################################################
   // storage and pointers
   //################################################

   always_ff @(posedge io_clk) begin
      if (push) begin
         data_mem[wr_ptr] <= core_data;
         mask_mem[wr_ptr] <= core_mask;
      end
   end

   // pointers wrap on their own, depth is a power of two
   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // push and pop together leave the level unchanged
   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         count_q <= '0;
      end else begin
         unique case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // head of queue, shown straight from memory
   assign buf_valid = (count_q != '0);
   assign buf_data  = data_mem[rd_ptr];
   assign buf_mask  = mask_mem[rd_ptr];
   assign buf_level = count_q;

   //################################################
   // checks
   //################################################

   // core must send 1..8 bytes packed from byte 0
   a_mask_shape: assert property (@(posedge io_clk) disable iff (!io_nreset)
      push |-> (core_mask != '0) && ((core_mask & (core_mask + 1'b1)) == '0))
      else $error("mtx_fifo: mask not contiguous from byte 0");

   // io stage must only pop a word that is there
   a_no_empty_pop: assert property (@(posedge io_clk) disable iff (!io_nreset)
      buf_pop |-> (count_q != '0))
      else $error("mtx_fifo: pop from empty buffer");

endmodule

// ==== hw/mtx_io.sv ====
`timescale 1ns/1ps

module mtx_io
   import mio_pkg::*;
(
   input  logic              io_clk,
   input  logic              io_nreset,
   // config
   input  logic              cfg_en,
   input  logic              cfg_ddr,
   input  io_width_e         cfg_width,
   // buffer side
   input  logic              buf_valid,
   input  logic [iow_w-1:0]  buf_data,
   input  logic [mask_w-1:0] buf_mask,
   output logic              buf_pop,
   // chip pins
   output logic [iow_w-1:0]  tx_packet,
   output logic              tx_access,
   input  logic              tx_wait,
   // to config block
   output logic              beat_sent,
   output logic              io_busy
);

   logic              wait_q1;     // first sync stage
   logic              wait_sync;   // second stage, safe to use
   logic [3:0]        lane_bytes;  // bytes per beat
   logic [6:0]        lane_bits;
   logic [mask_w-1:0] mask_q;      // bytes still to send
   logic [mask_w-1:0] mask_next;
   logic [iow_w-1:0]  data_q;      // lane 0 is next beat
   logic [iow_w-1:0]  data_next;
   logic              reload;
   logic              beat_go;     // beat captured into pins this edge
   logic [iow_w-1:0]  pin_q;       // sdr pins, low half is ddr rise data
   logic [ddr_w-1:0]  fall_q;      // ddr high half, low clock phase
   logic [ddr_w-1:0]  ddr_out;

   //################################################
   // wait synchronizer
   //################################################

   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         wait_q1   <= 1'b0;
         wait_sync <= 1'b0;
      end else begin
         wait_q1   <= tx_wait;
         wait_sync <= wait_q1;
      end
   end

   //################################################
   // beat shifter
   //################################################

   always_comb begin
      unique case (cfg_width)
         width_8:  lane_bytes = 4'd1;
         width_16: lane_bytes = 4'd2;
         width_32: lane_bytes = 4'd4;
         width_64: lane_bytes = 4'd8;
      endcase
   end

   assign lane_bits = 7'(lane_bytes * byte_w);
   assign mask_next = mask_q >> lane_bytes;   // width 64 empties it
   assign data_next = data_q >> lane_bits;

   // last beat of a word, or nothing in flight
   assign reload  = (mask_q == '0) || (cfg_width == width_64) || (mask_next == '0);
   assign buf_pop = cfg_en && reload && !wait_sync && buf_valid;
   assign io_busy = (mask_q != '0);

   // everything freezes under wait so no word is dropped
   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         mask_q <= '0;
      end else if (!wait_sync) begin
         if (reload) begin
            mask_q <= buf_pop ? buf_mask : '0;   // empty mask idles the link
         end else begin
            mask_q <= mask_next;
         end
      end
   end

   always_ff @(posedge io_clk) begin
      if (!wait_sync) begin
         data_q <= buf_pop ? buf_data : data_next;
      end
   end

   //################################################
   // access strobe and pin stage
   //################################################

   assign beat_go   = io_busy && !wait_sync;
   assign beat_sent = beat_go;                // one per captured beat

   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         tx_access <= 1'b0;
      end else begin
         tx_access <= beat_go;                // low the cycle after wait
      end
   end

   // only lowest lane bits carry meaning in sdr
   always_ff @(posedge io_clk) begin
      if (beat_go) begin
         pin_q <= data_q;
      end
   end

   // upper half waits for the falling edge
   always_ff @(negedge io_clk) begin
      fall_q <= pin_q[iow_w-1:ddr_w];
   end

   assign ddr_out   = io_clk ? pin_q[ddr_w-1:0] : fall_q;  // phase mux
   assign tx_packet = cfg_ddr ? {{(iow_w - ddr_w){1'b0}}, ddr_out} : pin_q;

   // bytes in flight stay packed from byte 0, else the beat count is off
   a_mask_packed: assert property (@(posedge io_clk) disable iff (!io_nreset)
      (mask_q & (mask_q + 1'b1)) == '0)
      else $error("mtx_io: shifter mask not packed from byte 0");

endmodule

// ==== verilog.f ====
hw/mio_pkg.sv
hw/mio_regs_pkg.sv
hw/mtx_cfg.sv
hw/mtx_fifo.sv
hw/mtx_io.sv
hw/mtx.sv
dv/mtx_tb_clk.sv
dv/mtx_tb.sv
